/* logic/memq_arbiter.sv */
/*
 * Round-robin choice between the two request FIFO heads.
 * Pops the granted FIFO and forwards its head as the store access,
 * all in the same cycle.
 */
`timescale 1ns/1ns

module memq_arbiter
    import memq_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic      [N_PORTS-1:0]  rok_i,
    input  memq_req_t [N_PORTS-1:0]  head_i,
    output logic      [N_PORTS-1:0]  pop_o,
    output logic                     acc_valid_o,
    output memq_req_t                acc_o,
    output logic                     acc_port_o
);

    // Port that wins when both heads are present
    logic prio_q;
    logic grant_port;
    logic both_ready;

    assign both_ready = rok_i[0] && rok_i[1];

    // Any ready head gives one access this cycle
    assign acc_valid_o = |rok_i;

    // Lone head wins, otherwise the priority holder
    assign grant_port = both_ready ? prio_q : rok_i[1];

    assign acc_port_o = grant_port;
    assign acc_o      = head_i[grant_port];

    // Pop only the granted FIFO
    always_comb begin
        for (int p = 0; p < N_PORTS; p++) begin
            pop_o[p] = acc_valid_o && (grant_port == p[0]);
        end
    end

    // Priority moves to the port not just served
    // Held when nothing was granted
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_q <= 1'b0;
        end else if (acc_valid_o) begin
            prio_q <= !grant_port;
        end
    end

endmodule

/* logic/memq_fifo.sv */
/*
 * Register FIFO with write-ok and read-ok strobes.
 * A push needs w_i with wok_o high, a pop needs r_i with rok_o high.
 * The head entry is presented combinationally on rdata_o.
 */
`timescale 1ns/1ns

module memq_fifo #(
    parameter int unsigned FIFO_DEPTH = 2,
    parameter type         fifo_data_t = logic
) (
    input  logic       clk_i,
    input  logic       rst_ni,
    input  logic       w_i,
    output logic       wok_o,
    input  fifo_data_t wdata_i,
    input  logic       r_i,
    output logic       rok_o,
    output fifo_data_t rdata_o
);

    typedef logic [$clog2(FIFO_DEPTH)-1:0] ptr_t;

    // Entry storage
    fifo_data_t [FIFO_DEPTH-1:0] mem_q;

    ptr_t rd_ptr_q;
    ptr_t rd_ptr_d;
    ptr_t wr_ptr_q;
    ptr_t wr_ptr_d;
    // Set when the write pointer has wrapped past the read pointer
    logic wrap_q;
    logic wrap_d;
    logic do_rd;
    logic do_wr;
    logic rd_last;
    logic wr_last;
    logic same_ptr;

    // Equal pointers mean full or empty, the wrap flag tells which
    assign same_ptr = (rd_ptr_q == wr_ptr_q);
    assign rok_o    = same_ptr ? wrap_q : 1'b1;
    assign wok_o    = same_ptr ? !wrap_q : 1'b1;

    // Strobes only act while the matching ok is high
    assign do_rd = r_i && rok_o;
    assign do_wr = w_i && wok_o;

    assign rd_last = (rd_ptr_q == ptr_t'(FIFO_DEPTH - 1));
    assign wr_last = (wr_ptr_q == ptr_t'(FIFO_DEPTH - 1));

    // Next pointer and wrap state
    always_comb begin
        rd_ptr_d = rd_ptr_q;
        wr_ptr_d = wr_ptr_q;
        wrap_d   = wrap_q;
        if (do_rd) begin
            rd_ptr_d = rd_last ? '0 : rd_ptr_q + 1'b1;
        end
        if (do_wr) begin
            wr_ptr_d = wr_last ? '0 : wr_ptr_q + 1'b1;
        end
        // Reader catching up clears the wrap, writer wrapping sets it
        if (do_rd && rd_last) begin
            wrap_d = 1'b0;
        end else if (do_wr && wr_last) begin
            wrap_d = 1'b1;
        end
    end

    // Push into the slot under the write pointer
    always_ff @(posedge clk_i) begin
        if (do_wr) begin
            mem_q[wr_ptr_q] <= wdata_i;
        end
    end

    // Head entry
    assign rdata_o = mem_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            wrap_q   <= 1'b0;
        end else begin
            rd_ptr_q <= rd_ptr_d;
            wr_ptr_q <= wr_ptr_d;
            wrap_q   <= wrap_d;
        end
    end

    // Read pointer never overtakes the write pointer
    always @(posedge clk_i) begin
        if (rst_ni) begin
            ptr_order_chk: assert ((!wrap_q && (rd_ptr_q <= wr_ptr_q)) ||
                                   (wrap_q && (rd_ptr_q >= wr_ptr_q)))
                else $error("memq_fifo: read pointer passed write pointer");
        end
    end

endmodule

/* logic/memq_pkg.sv */
/*
 * Shared sizes and types for the memory request queue.
 * Modules take these in through a wildcard import in their header.
 * The request payload is a union because it is decoded by the request kind.
 */
package memq_pkg;

    // Store and bus sizes
    localparam int unsigned DATA_W    = 32;
    localparam int unsigned ADDR_W    = 4;
    localparam int unsigned MEM_WORDS = 16;
    localparam int unsigned TAG_W     = 8;

    // Requester side
    localparam int unsigned N_PORTS        = 2;
    localparam int unsigned REQ_FIFO_DEPTH = 4;

    // One-bit request kind
    typedef enum logic {
        MEMQ_RD = 1'b0,
        MEMQ_WR = 1'b1
    } memq_op_e;

    // Read view of the payload word
    // Tag sits in the low bits, the rest is padding
    typedef struct packed {
        logic [DATA_W-TAG_W-1:0] pad;
        logic [TAG_W-1:0]        tag;
    } memq_rd_payload_t;

    // Write data for a write, tag for a read
    typedef union packed {
        logic [DATA_W-1:0] wdata;
        memq_rd_payload_t  rd;
    } memq_payload_u;

    // Request as pushed by a requester
    typedef struct packed {
        memq_op_e          op;
        logic [ADDR_W-1:0] addr;
        memq_payload_u     payload;
    } memq_req_t;

    // Read response, shared by both ports
    typedef struct packed {
        logic [DATA_W-1:0] rdata;
        logic [TAG_W-1:0]  tag;
    } memq_rsp_t;

endpackage

/* logic/memq_store.sv */
/*
 * Shared word store behind the arbiter.
 * Writes land at the access edge, reads answer one cycle later
 * with a valid pulse on the issuing port only.
 */
`timescale 1ns/1ns

module memq_store
    import memq_pkg::*;
(
    input  logic                clk_i,
    input  logic                rst_ni,
    input  logic                acc_valid_i,
    input  memq_req_t           acc_i,
    input  logic                acc_port_i,
    output logic [N_PORTS-1:0]  rsp_valid_o,
    output memq_rsp_t           rsp_o
);

    // Word array, cleared by reset
    logic [DATA_W-1:0] mem_q [MEM_WORDS];

    logic [N_PORTS-1:0] rsp_valid_q;
    memq_rsp_t          rsp_q;
    logic               wr_acc;
    logic               rd_acc;

    assign wr_acc = acc_valid_i && (acc_i.op == MEMQ_WR);
    assign rd_acc = acc_valid_i && (acc_i.op == MEMQ_RD);

    // Write takes the payload as data
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            for (int w = 0; w < MEM_WORDS; w++) begin
                mem_q[w] <= '0;
            end
        end else if (wr_acc) begin
            mem_q[acc_i.addr] <= acc_i.payload.wdata;
        end
    end

    // Valid pulse routed to the port that issued the read
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_valid_q <= '0;
        end else begin
            for (int p = 0; p < N_PORTS; p++) begin
                rsp_valid_q[p] <= rd_acc && (acc_port_i == p[0]);
            end
        end
    end

    // Read word and tag from the rd view of the payload
    always_ff @(posedge clk_i) begin
        if (rd_acc) begin
            rsp_q.rdata <= mem_q[acc_i.addr];
            rsp_q.tag   <= acc_i.payload.rd.tag;
        end
    end

    assign rsp_valid_o = rsp_valid_q;
    assign rsp_o       = rsp_q;

endmodule

/* logic/memq_top.sv */
/*
 * Memory request queue top level.
 * Each requester pushes into its own FIFO, the arbiter picks one head
 * per cycle and the store answers reads on the shared response bus.
 */
`timescale 1ns/1ns

module memq_top
    import memq_pkg::*;
(
    input  logic                     clk_i,
    input  logic                     rst_ni,
    input  logic      [N_PORTS-1:0]  req_w_i,
    input  memq_req_t [N_PORTS-1:0]  req_i,
    output logic      [N_PORTS-1:0]  req_wok_o,
    output logic      [N_PORTS-1:0]  rsp_valid_o,
    output memq_rsp_t                rsp_o
);

    // FIFO heads towards the arbiter
    logic      [N_PORTS-1:0] fifo_rok;
    memq_req_t [N_PORTS-1:0] fifo_head;
    logic      [N_PORTS-1:0] fifo_pop;

    // Granted access towards the store
    logic      acc_valid;
    memq_req_t acc;
    logic      acc_port;

    // One request FIFO per requester
    for (genvar p = 0; p < N_PORTS; p++) begin : g_port
        memq_fifo #(
            .FIFO_DEPTH  (REQ_FIFO_DEPTH),
            .fifo_data_t (memq_req_t)
        ) u_req_fifo (
            .clk_i   (clk_i),
            .rst_ni  (rst_ni),
            .w_i     (req_w_i[p]),
            .wok_o   (req_wok_o[p]),
            .wdata_i (req_i[p]),
            .r_i     (fifo_pop[p]),
            .rok_o   (fifo_rok[p]),
            .rdata_o (fifo_head[p])
        );
    end

    memq_arbiter u_arbiter (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .rok_i       (fifo_rok),
        .head_i      (fifo_head),
        .pop_o       (fifo_pop),
        .acc_valid_o (acc_valid),
        .acc_o       (acc),
        .acc_port_o  (acc_port)
    );

    // Single response bus, rsp_valid_o says which port owns it
    memq_store u_store (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .acc_valid_i (acc_valid),
        .acc_i       (acc),
        .acc_port_i  (acc_port),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

endmodule

/* verif/memq_assertions.sv */
/*
 * Concurrent checks on the FIFO pops and the response valids.
 * Bound into memq_top so the internal arbiter strobes are visible.
 */
`timescale 1ns/1ns

module memq_assertions
    import memq_pkg::*;
(
    input logic               clk_i,
    input logic               rst_ni,
    input logic [N_PORTS-1:0] fifo_pop_i,
    input logic [N_PORTS-1:0] fifo_rok_i,
    input logic [N_PORTS-1:0] rsp_valid_i
);

    // Count of failed checks
    int fail_cnt = 0;

    // Arbiter grants a single head per cycle
    one_pop: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(fifo_pop_i))
        else begin
            fail_cnt++;
            $error("more than one request FIFO popped in one cycle");
        end

    // Pop only from a FIFO that has a head
    pop_ready: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (fifo_pop_i & ~fifo_rok_i) == '0)
        else begin
            fail_cnt++;
            $error("request FIFO popped while empty");
        end

    // Shared response bus owned by one port at a time
    one_rsp: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(rsp_valid_i))
        else begin
            fail_cnt++;
            $error("response valid on both ports at once");
        end

endmodule

bind memq_top memq_assertions u_assertions (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .fifo_pop_i  (fifo_pop),
    .fifo_rok_i  (fifo_rok),
    .rsp_valid_i (rsp_valid_o)
);

/* verif/memq_tb.sv */
/*
 * Testbench for the memory request queue.
 * Drives both ports with directed and LCG traffic, models every accepted
 * request and checks each read response against the model.
 */
`timescale 1ns/1ns

module memq_tb
    import memq_pkg::*;
();

    logic                    clk_i;
    logic                    rst_ni;
    logic      [N_PORTS-1:0] req_w;
    memq_req_t [N_PORTS-1:0] req;
    logic      [N_PORTS-1:0] req_wok;
    logic      [N_PORTS-1:0] rsp_valid;
    memq_rsp_t               rsp;

    // Model memory and expected responses per port
    logic [DATA_W-1:0] ref_mem [MEM_WORDS];
    memq_rsp_t         exp_q0 [$];
    memq_rsp_t         exp_q1 [$];
    logic [31:0]       lcg_state;
    int                errors;
    int                assert_errors;
    int                last_port;
    logic              fair_en;
    logic              saw_full;
    logic              timed_out;

    memq_top memq_top_inst (
        .clk_i       (clk_i),
        .rst_ni      (rst_ni),
        .req_w_i     (req_w),
        .req_i       (req),
        .req_wok_o   (req_wok),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    always #5 clk_i = !clk_i;

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function logic [31:0] rand_word();
        lcg_state = lcg_next(lcg_state);
        return lcg_state;
    endfunction

    function automatic memq_req_t make_req(input memq_op_e op, input int addr,
                                           input logic [DATA_W-1:0] word);
        memq_req_t r;
        r.op            = op;
        r.addr          = addr[ADDR_W-1:0];
        r.payload.wdata = word;
        return r;
    endfunction

    // Port 0 owns words 0-7, port 1 owns 8-15
    function memq_req_t rand_req(input int port);
        logic [31:0] x;
        x = rand_word();
        return make_req(x[31] ? MEMQ_WR : MEMQ_RD, port * 8 + x[30:28], rand_word());
    endfunction

    // Reference model, applied in acceptance order
    function void model_accept(input int port, input memq_req_t r);
        memq_rsp_t e;
        if (r.op == MEMQ_WR) begin
            ref_mem[r.addr] = r.payload.wdata;
        end else begin
            e.rdata = ref_mem[r.addr];
            e.tag   = r.payload.rd.tag;
            if (port == 0) begin
                exp_q0.push_back(e);
            end else begin
                exp_q1.push_back(e);
            end
        end
    endfunction

    task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            errors++;
            $display("[FAIL] %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    // Compare responses first, then record this cycle's accepted pushes
    always @(negedge clk_i) begin
        memq_rsp_t e;
        logic      both_busy;
        if (rst_ni) begin
            both_busy = (exp_q0.size() > 0) && (exp_q1.size() > 0);
            for (int p = 0; p < N_PORTS; p++) begin
                if (rsp_valid[p]) begin
                    if (fair_en && both_busy && last_port == p) begin
                        errors++;
                        $display("Port %0d was served twice in a row while both waited", p);
                    end
                    last_port = p;
                    if ((p == 0 && exp_q0.size() == 0) || (p == 1 && exp_q1.size() == 0)) begin
                        errors++;
                        $display("Unexpected response on port %0d at %0t ns", p, $time);
                    end else begin
                        if (p == 0) begin
                            e = exp_q0.pop_front();
                        end else begin
                            e = exp_q1.pop_front();
                        end
                        check($sformatf("port %0d read data", p), rsp.rdata, e.rdata);
                        check($sformatf("port %0d read tag", p), rsp.tag, e.tag);
                    end
                end
                if (req_w[p] && req_wok[p]) begin
                    model_accept(p, req[p]);
                end else if (req_w[p]) begin
                    saw_full = 1'b1;
                end
            end
        end
    end

    task automatic drive(input logic [N_PORTS-1:0] w, input memq_req_t r0, input memq_req_t r1);
        @(posedge clk_i);
        #1;
        req_w  = w;
        req[0] = r0;
        req[1] = r1;
    endtask

    task automatic wait_drain();
        int cycles;
        cycles = 0;
        while ((exp_q0.size() != 0 || exp_q1.size() != 0) && cycles < 100) begin
            @(posedge clk_i);
            cycles++;
        end
        if (exp_q0.size() != 0 || exp_q1.size() != 0) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: read responses never arrived, %0d on port 0, %0d on port 1",
                     exp_q0.size(), exp_q1.size());
        end
    endtask

    task automatic run_all();
        logic [31:0] x;
        // Reset state and idle bus
        check("port 0 wok after reset", req_wok[0], 1'b1);
        check("port 1 wok after reset", req_wok[1], 1'b1);
        repeat (6) drive(2'b00, '0, '0);
        check("rsp_valid while idle", rsp_valid, 2'b00);
        for (int a = 0; a < 8; a++) begin
            drive(2'b11, make_req(MEMQ_RD, a, a), make_req(MEMQ_RD, a + 8, a + 8));
            drive(2'b00, '0, '0);
        end
        wait_drain();
        if (timed_out) return;
        // Write then read back on one port
        drive(2'b01, make_req(MEMQ_WR, 3, 32'h5a5a_c3c3), '0);
        drive(2'b01, make_req(MEMQ_RD, 3, 32'h0000_0077), '0);
        drive(2'b00, '0, '0);
        wait_drain();
        if (timed_out) return;
        // Mixed random traffic
        for (int i = 0; i < 150; i++) begin
            x = rand_word();
            drive(x[31:30], rand_req(0), rand_req(1));
        end
        drive(2'b00, '0, '0);
        wait_drain();
        if (timed_out) return;
        // Let writes still queued behind the last reads leave both FIFOs
        // Two full FIFOs empty within depth times ports cycles
        repeat (REQ_FIFO_DEPTH * N_PORTS) drive(2'b00, '0, '0);
        // Reads pushed on both ports together must alternate
        fair_en   = 1'b1;
        last_port = -1;
        for (int i = 0; i < 4; i++) begin
            drive(2'b11, make_req(MEMQ_RD, i, 8'h10 + i), make_req(MEMQ_RD, i + 8, 8'h20 + i));
        end
        drive(2'b00, '0, '0);
        wait_drain();
        fair_en = 1'b0;
        if (timed_out) return;
        // Push every cycle until the FIFOs fill up
        saw_full = 1'b0;
        for (int i = 0; i < 24; i++) begin
            drive(2'b11, rand_req(0), rand_req(1));
        end
        drive(2'b00, '0, '0);
        wait_drain();
        if (timed_out) return;
        check("wok dropped under back-pressure", saw_full, 1'b1);
        repeat (4) drive(2'b00, '0, '0);
    endtask

    initial begin
        clk_i     = 1'b0;
        rst_ni    = 1'b0;
        req_w     = '0;
        req       = '0;
        lcg_state = 32'hdc0eca0c;
        errors    = 0;
        last_port = -1;
        fair_en   = 1'b0;
        saw_full  = 1'b0;
        timed_out = 1'b0;
        for (int w = 0; w < MEM_WORDS; w++) begin
            ref_mem[w] = '0;
        end
        repeat (4) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;
        run_all();
        assert_errors = memq_top_inst.u_assertions.fail_cnt;
        $display("Run complete with %0d check errors and %0d assertion failures",
                 errors, assert_errors);
        if (errors == 0 && assert_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
logic/memq_pkg.sv
logic/memq_fifo.sv
logic/memq_arbiter.sv
logic/memq_store.sv
logic/memq_top.sv
verif/memq_assertions.sv
verif/memq_tb.sv
